// ==== common/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// Integer register count
`define RV_NUM_REGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== common/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Instruction class, NONE for bubbles and undecoded words
    typedef enum logic [2:0] {
        NONE,
        ALU_R,
        ALU_I,
        LUI,
        LOAD,
        STORE,
        BRANCH,
        JAL
    } ir_class_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_e;

    // Operand source picked in ID
    typedef enum logic [1:0] {
        REGFILE,
        FROM_EX,
        FROM_MEM
    } fwd_sel_e;

endpackage

// ==== decode/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic                i_interlock,
    input  rv_pkg::word_t       i_pc,
    input  rv_pkg::word_t       i_pc4,
    input  rv_pkg::word_t       i_ir,
    input  rv_pkg::word_t       i_rf_data1,
    input  rv_pkg::word_t       i_rf_data2,
    input  rv_pkg::word_t       i_fwd_ex,
    input  rv_pkg::word_t       i_fwd_mem,
    input  rv_pkg::fwd_sel_e    i_fwd1,
    input  rv_pkg::fwd_sel_e    i_fwd2,
    output rv_pkg::reg_addr_t   o_rs1,
    output rv_pkg::reg_addr_t   o_rs2,
    output rv_pkg::ir_class_e   o_id_class,
    output rv_pkg::ir_class_e   o_ex_class,
    output rv_pkg::alu_op_e     o_ex_alu_op,
    output rv_pkg::word_t       o_ex_op1,
    output rv_pkg::word_t       o_ex_op2,
    output rv_pkg::word_t       o_ex_imm,
    output rv_pkg::word_t       o_ex_pc,
    output rv_pkg::word_t       o_ex_pc4,
    output rv_pkg::reg_addr_t   o_ex_rd,
    output logic                o_ex_wr_en
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    rv_pkg::alu_op_e  alu_op;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    op1;
    rv_pkg::word_t    op2;
    logic             wr_en;

    function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  return rv_pkg::SLL;
            3'b010:  return rv_pkg::SLT;
            3'b011:  return rv_pkg::SLTU;
            3'b100:  return rv_pkg::XOR;
            3'b101:  return alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  return rv_pkg::OR;
            default: return rv_pkg::AND;
        endcase
    endfunction

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t rf_data,
                                              input rv_pkg::word_t ex_data,
                                              input rv_pkg::word_t mem_data);
        case (sel)
            rv_pkg::FROM_EX:  return ex_data;
            rv_pkg::FROM_MEM: return mem_data;
            default:          return rf_data;
        endcase
    endfunction

    assign opcode = i_ir[6:0];
    assign funct3 = i_ir[14:12];
    assign o_rs1  = i_ir[19:15];
    assign o_rs2  = i_ir[24:20];

    always_comb begin
        o_id_class = rv_pkg::NONE;
        alu_op     = rv_pkg::ADD;
        imm        = {{20{i_ir[31]}}, i_ir[31:20]};
        case (opcode)
            7'b0110011: begin
                o_id_class = rv_pkg::ALU_R;
                alu_op     = alu_decode(funct3, i_ir[30], 1'b1);
            end
            7'b0010011: begin
                o_id_class = rv_pkg::ALU_I;
                alu_op     = alu_decode(funct3, i_ir[30], 1'b0);
            end
            7'b0110111: begin
                o_id_class = rv_pkg::LUI;
                alu_op     = rv_pkg::PASS_B;
                imm        = {i_ir[31:12], 12'b0};
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    o_id_class = rv_pkg::LOAD;
                end
            end
            7'b0100011: begin
                imm = {{20{i_ir[31]}}, i_ir[31:25], i_ir[11:7]};
                if (funct3 == 3'b010) begin
                    o_id_class = rv_pkg::STORE;
                end
            end
            7'b1100011: begin
                imm = {{19{i_ir[31]}}, i_ir[31], i_ir[7], i_ir[30:25], i_ir[11:8], 1'b0};
                // BEQ goes through SUB, BNE through XOR; EX tests the result for zero
                if (funct3 == 3'b000) begin
                    o_id_class = rv_pkg::BRANCH;
                    alu_op     = rv_pkg::SUB;
                end else if (funct3 == 3'b001) begin
                    o_id_class = rv_pkg::BRANCH;
                    alu_op     = rv_pkg::XOR;
                end
            end
            7'b1101111: begin
                o_id_class = rv_pkg::JAL;
                imm = {{11{i_ir[31]}}, i_ir[31], i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    assign wr_en = o_id_class inside {rv_pkg::ALU_R, rv_pkg::ALU_I, rv_pkg::LUI,
                                      rv_pkg::LOAD, rv_pkg::JAL};

    assign op1 = fwd_mux(i_fwd1, i_rf_data1, i_fwd_ex, i_fwd_mem);
    assign op2 = fwd_mux(i_fwd2, i_rf_data2, i_fwd_ex, i_fwd_mem);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_class  <= rv_pkg::NONE;
            o_ex_alu_op <= rv_pkg::ADD;
            o_ex_wr_en  <= 1'b0;
        end else if (!i_interlock) begin
            if (i_stall || i_flush) begin
                o_ex_class <= rv_pkg::NONE;
                o_ex_wr_en <= 1'b0;
            end else begin
                o_ex_class  <= o_id_class;
                o_ex_alu_op <= alu_op;
                o_ex_wr_en  <= wr_en;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_interlock) begin
            o_ex_op1 <= op1;
            o_ex_op2 <= op2;
            o_ex_imm <= imm;
            o_ex_pc  <= i_pc;
            o_ex_pc4 <= i_pc4;
            o_ex_rd  <= i_ir[11:7];
        end
    end

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst
);

    int   rst_left;
    logic req;

    initial begin
        o_clk    = 1'b0;
        o_rst    = 1'b1;
        rst_left = 4;
        forever #4 o_clk = ~o_clk;
    end

    // Reset spans four rising edges and moves 1 ns after an edge
    always @(posedge o_clk) begin
        req = i_rst_req;
        #1;
        if (req) begin
            rst_left = 4;
        end else if (rst_left > 0) begin
            rst_left = rst_left - 1;
        end
        o_rst = (rst_left != 0);
    end

endmodule

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_params.svh"

module tb_rv_core;

    localparam rv_pkg::word_t DONE_ADDR = 32'h100;
    localparam int            MEM_WORDS = 256;
    localparam logic [6:0]    OP_IMM    = 7'b0010011;
    localparam logic [6:0]    OP_LOAD   = 7'b0000011;

    logic           clk;
    logic           rst;
    logic           rst_req;
    logic           acki_n;
    logic           ackd_n;
    logic           mreq;
    logic           write;
    logic [1:0]     size;
    rv_pkg::word_t  iad;
    rv_pkg::word_t  idt;
    rv_pkg::word_t  dad;
    rv_pkg::word_t  ddt_out;
    rv_pkg::word_t  ddt_in;

    rv_pkg::word_t  imem [MEM_WORDS];
    rv_pkg::word_t  dmem [MEM_WORDS];
    rv_pkg::word_t  log_addr [$];
    rv_pkg::word_t  log_data [$];
    rv_pkg::word_t  exp_addr [$];
    rv_pkg::word_t  exp_data [$];
    rv_pkg::word_t  asm_pc;
    rv_pkg::word_t  pend_addr;
    rv_pkg::word_t  pend_data;
    logic           pending;
    logic           done;
    logic           wait_mode;
    logic           dbusy;
    int             iwait;
    int             dwait;
    int             checks;
    int             errors;
    int unsigned    seed;

    tb_clkgen clkgen_i (.i_rst_req(rst_req), .o_clk(clk), .o_rst(rst));

    rv_core_top dut_i (
        .clk(clk), .i_rst(rst), .o_iad(iad), .i_idt(idt), .i_acki_n(acki_n),
        .o_dad(dad), .o_ddt(ddt_out), .i_ddt(ddt_in), .o_mreq(mreq), .o_write(write),
        .o_size(size), .i_ackd_n(ackd_n)
    );

    // Both memories answer within the cycle
    assign idt    = imem[iad[9:2]];
    assign ddt_in = dmem[dad[9:2]];

    function automatic rv_pkg::word_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t itype(input logic [31:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t stype(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t btype(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic rv_pkg::word_t jtype(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_equal(input string name, input rv_pkg::word_t got,
                                input rv_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(input rv_pkg::word_t word);
        imem[asm_pc[9:2]] = word;
        asm_pc = asm_pc + 32'd4;
    endtask

    task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Store to the done address, then spin on a jump to itself
    task automatic emit_done();
        emit(stype(DONE_ADDR, 5'd0, 5'd0));
        emit(jtype(32'd0, 5'd0));
        expect_store(DONE_ADDR, 32'd0);
    endtask

    task automatic clear_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // Filler is ADDI x0, x0, index
            imem[i] = {i[11:0], 20'h00013};
            dmem[i] = {16'hd0a7, i[15:0]};
        end
        asm_pc = `RV_RESET_VECTOR;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        pending = 1'b0;
        done    = 1'b0;
    endtask

    task automatic apply_reset(input bit check_outputs);
        int n;
        @(posedge clk);
        #1;
        rst_req = 1'b1;
        acki_n  = 1'b0;
        ackd_n  = 1'b0;
        iwait   = 0;
        dbusy   = 1'b0;
        @(posedge clk);
        #1;
        rst_req = 1'b0;
        // First edge with the core in reset
        @(posedge clk);
        n = 0;
        do begin
            @(negedge clk);
            if (check_outputs) begin
                expect_equal("o_mreq", mreq, 32'd0);
                expect_equal("o_write", write, 32'd0);
                expect_equal("o_iad", iad, `RV_RESET_VECTOR);
            end
            n++;
        end while (rst && n < 10);
        if (rst) begin
            errors++;
            $display("Reset stayed asserted for more than %0d cycles", n);
        end
    endtask

    // Samples the data bus at the falling edge
    task automatic observe();
        if (pending) begin
            expect_equal("o_write", write, 32'd1);
            expect_equal("o_dad", dad, pend_addr);
            expect_equal("o_ddt", ddt_out, pend_data);
        end
        pending = 1'b0;
        if (mreq === 1'b1) begin
            expect_equal("o_size", size, 32'd2);
            if (!ackd_n && !acki_n) begin
                dbusy = 1'b0;
            end
        end
        if (mreq === 1'b1 && write === 1'b1) begin
            if (!ackd_n) begin
                dmem[dad[9:2]] = ddt_out;
            end
            if (!ackd_n && !acki_n) begin
                log_addr.push_back(dad);
                log_data.push_back(ddt_out);
                if (dad == DONE_ADDR) begin
                    done = 1'b1;
                end
            end else begin
                pending   = 1'b1;
                pend_addr = dad;
                pend_data = ddt_out;
            end
        end
    endtask

    task automatic drive_acks();
        if (!wait_mode) begin
            acki_n = 1'b0;
            ackd_n = 1'b0;
        end else begin
            // New fetch delay once the last one was acknowledged
            if (!acki_n) begin
                iwait = $urandom % 4;
            end else begin
                iwait = iwait - 1;
            end
            acki_n = (iwait != 0);
            if (mreq === 1'b1) begin
                if (!dbusy) begin
                    dbusy = 1'b1;
                    dwait = $urandom % 4;
                end else if (dwait != 0) begin
                    dwait = dwait - 1;
                end
                ackd_n = (dwait != 0);
            end else begin
                ackd_n = 1'b1;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        observe();
        @(posedge clk);
        #1;
        drive_acks();
    endtask

    task automatic run_until_done();
        int n;
        n = 0;
        while (!done && n < 1000) begin
            step();
            n++;
        end
        if (!done) begin
            errors++;
            $display("Timeout: no store to the done address within %0d cycles", n);
        end
    endtask

    task automatic compare_log(input string test);
        int n;
        expect_equal({test, " store count"}, log_addr.size(), exp_addr.size());
        n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            expect_equal($sformatf("%s store %0d address", test, i), log_addr[i], exp_addr[i]);
            expect_equal($sformatf("%s store %0d data", test, i), log_data[i], exp_data[i]);
        end
    endtask

    task automatic reset_values();
        clear_memories();
        wait_mode = 1'b0;
        emit_done();
        apply_reset(1'b1);
        run_until_done();
        compare_log("reset");
    endtask

    task automatic alu_forwarding(input bit waits);
        rv_pkg::word_t r [32];
        clear_memories();
        wait_mode = waits;
        emit(utype(20'h12345, 5'd1));
        r[1] = 32'h1234_5000;
        emit(itype(32'h678, 1, 3'b000, 2, OP_IMM));
        r[2] = r[1] + 32'h678;
        emit(rtype(7'h20, 1, 2, 3'b000, 3));
        r[3] = r[2] - r[1];
        emit(itype(-1, 3, 3'b100, 4, OP_IMM));
        r[4] = ~r[3];
        emit(itype(4, 4, 3'b001, 5, OP_IMM));
        r[5] = r[4] << 4;
        emit(itype(32'h402, 5, 3'b101, 6, OP_IMM));
        r[6] = $signed(r[5]) >>> 2;
        emit(itype(3, 5, 3'b101, 7, OP_IMM));
        r[7] = r[5] >> 3;
        emit(rtype(7'h00, 3, 2, 3'b001, 8));
        r[8] = r[2] << r[3][4:0];
        emit(rtype(7'h20, 3, 4, 3'b101, 9));
        r[9] = $signed(r[4]) >>> r[3][4:0];
        emit(rtype(7'h00, 3, 4, 3'b101, 10));
        r[10] = r[4] >> r[3][4:0];
        emit(rtype(7'h00, 4, 2, 3'b111, 11));
        r[11] = r[2] & r[4];
        emit(rtype(7'h00, 1, 3, 3'b110, 12));
        r[12] = r[3] | r[1];
        emit(rtype(7'h00, 11, 12, 3'b100, 13));
        r[13] = r[12] ^ r[11];
        emit(rtype(7'h00, 3, 4, 3'b010, 14));
        r[14] = ($signed(r[4]) < $signed(r[3])) ? 32'd1 : 32'd0;
        emit(rtype(7'h00, 3, 4, 3'b011, 15));
        r[15] = (r[4] < r[3]) ? 32'd1 : 32'd0;
        emit(itype(5, 4, 3'b010, 16, OP_IMM));
        r[16] = ($signed(r[4]) < $signed(32'd5)) ? 32'd1 : 32'd0;
        emit(itype(-1, 3, 3'b011, 17, OP_IMM));
        r[17] = (r[3] < 32'hffff_ffff) ? 32'd1 : 32'd0;
        emit(rtype(7'h00, 17, 14, 3'b000, 18));
        r[18] = r[14] + r[17];
        emit(itype(32'h0ff, 2, 3'b111, 19, OP_IMM));
        r[19] = r[2] & 32'h0000_00ff;
        emit(itype(-256, 19, 3'b110, 20, OP_IMM));
        r[20] = r[19] | 32'hffff_ff00;
        // Newest result first so the first stores forward from EX
        for (int i = 20; i >= 1; i--) begin
            emit(stype(32'h200 + 4 * i, i[4:0], 5'd0));
            expect_store(32'h200 + 4 * i, r[i]);
        end
        emit_done();
        apply_reset(1'b0);
        run_until_done();
        compare_log(waits ? "wait states" : "alu chain");
    endtask

    task automatic load_use();
        rv_pkg::word_t v;
        clear_memories();
        wait_mode = 1'b0;
        v = 32'habcd_e111;
        emit(utype(20'habcde, 5'd1));
        emit(itype(32'h111, 1, 3'b000, 1, OP_IMM));
        emit(itype(32'h055, 0, 3'b000, 2, OP_IMM));
        emit(stype(32'h300, 1, 0));
        emit(itype(32'h300, 0, 3'b010, 3, OP_LOAD));
        emit(rtype(7'h00, 2, 3, 3'b000, 4));
        emit(stype(32'h304, 4, 0));
        emit(itype(32'h304, 0, 3'b010, 5, OP_LOAD));
        // Store data taken straight from the load
        emit(stype(32'h308, 5, 0));
        expect_store(32'h300, v);
        expect_store(32'h304, v + 32'h55);
        expect_store(32'h308, v + 32'h55);
        emit_done();
        apply_reset(1'b0);
        run_until_done();
        compare_log("load use");
    endtask

    task automatic branch_flush();
        rv_pkg::word_t link;
        clear_memories();
        wait_mode = 1'b0;
        emit(itype(7, 0, 3'b000, 1, OP_IMM));
        emit(itype(7, 0, 3'b000, 2, OP_IMM));
        emit(btype(12, 2, 1, 3'b000));
        emit(stype(32'h380, 1, 0));
        emit(stype(32'h384, 1, 0));
        // Equal operands, so BNE falls through
        emit(btype(12, 2, 1, 3'b001));
        emit(stype(32'h388, 2, 0));
        emit(btype(12, 0, 1, 3'b001));
        emit(stype(32'h38c, 1, 0));
        emit(stype(32'h390, 1, 0));
        link = asm_pc + 32'd4;
        emit(jtype(12, 5));
        emit(stype(32'h394, 1, 0));
        emit(stype(32'h398, 1, 0));
        emit(stype(32'h39c, 5, 0));
        expect_store(32'h388, 32'd7);
        expect_store(32'h39c, link);
        emit_done();
        apply_reset(1'b0);
        run_until_done();
        compare_log("branch");
    endtask

    initial begin
        rst_req   = 1'b0;
        acki_n    = 1'b0;
        ackd_n    = 1'b0;
        wait_mode = 1'b0;
        dbusy     = 1'b0;
        iwait     = 0;
        dwait     = 0;
        checks    = 0;
        errors    = 0;
        seed      = 32'hec700605;
        void'($urandom(seed));
        clear_memories();

        reset_values();
        alu_forwarding(1'b0);
        load_use();
        branch_flush();
        alu_forwarding(1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== execute/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_interlock,
    input  rv_pkg::ir_class_e   i_ex_class,
    input  rv_pkg::alu_op_e     i_ex_alu_op,
    input  rv_pkg::word_t       i_ex_op1,
    input  rv_pkg::word_t       i_ex_op2,
    input  rv_pkg::word_t       i_ex_imm,
    input  rv_pkg::word_t       i_ex_pc,
    input  rv_pkg::word_t       i_ex_pc4,
    input  rv_pkg::reg_addr_t   i_ex_rd,
    input  logic                i_ex_wr_en,
    output logic                o_jump,
    output rv_pkg::word_t       o_jump_target,
    output rv_pkg::word_t       o_ex_result,
    output rv_pkg::word_t       o_mem_result,
    output rv_pkg::word_t       o_mem_store_data,
    output rv_pkg::word_t       o_mem_pc4,
    output rv_pkg::reg_addr_t   o_mem_rd,
    output logic                o_mem_wr_en,
    output rv_pkg::ir_class_e   o_mem_class
);

    rv_pkg::word_t  op_b;
    rv_pkg::word_t  alu;
    logic [4:0]     shamt;
    logic           zero;

    assign op_b  = (i_ex_class inside {rv_pkg::ALU_I, rv_pkg::LUI, rv_pkg::LOAD, rv_pkg::STORE})
                   ? i_ex_imm : i_ex_op2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ex_alu_op)
            rv_pkg::ADD:  alu = i_ex_op1 + op_b;
            rv_pkg::SUB:  alu = i_ex_op1 - op_b;
            rv_pkg::AND:  alu = i_ex_op1 & op_b;
            rv_pkg::OR:   alu = i_ex_op1 | op_b;
            rv_pkg::XOR:  alu = i_ex_op1 ^ op_b;
            rv_pkg::SLT:  alu = {31'b0, $signed(i_ex_op1) < $signed(op_b)};
            rv_pkg::SLTU: alu = {31'b0, i_ex_op1 < op_b};
            rv_pkg::SLL:  alu = i_ex_op1 << shamt;
            rv_pkg::SRL:  alu = i_ex_op1 >> shamt;
            rv_pkg::SRA:  alu = $signed(i_ex_op1) >>> shamt;
            default:      alu = op_b;
        endcase
    end

    assign zero = (alu == '0);

    // SUB marks BEQ, XOR marks BNE
    assign o_jump = (i_ex_class == rv_pkg::JAL) ||
                    ((i_ex_class == rv_pkg::BRANCH) && ((i_ex_alu_op == rv_pkg::SUB) == zero));
    assign o_jump_target = i_ex_pc + i_ex_imm;

    // Link value seen by forwarding
    assign o_ex_result = (i_ex_class == rv_pkg::JAL) ? i_ex_pc4 : alu;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_class <= rv_pkg::NONE;
            o_mem_wr_en <= 1'b0;
        end else if (!i_interlock) begin
            o_mem_class <= i_ex_class;
            o_mem_wr_en <= i_ex_wr_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_interlock) begin
            o_mem_result     <= alu;
            o_mem_store_data <= i_ex_op2;
            o_mem_pc4        <= i_ex_pc4;
            o_mem_rd         <= i_ex_rd;
        end
    end

    // Taken jumps land on word addresses
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_jump |-> (o_jump_target[1:0] == 2'b00));

endmodule

// ==== project.f ====
+incdir+common
common/rv_pkg.sv
rtl/if_stage.sv
decode/id_stage.sv
execute/ex_stage.sv
rtl/mem_wb_stage.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/rv_core_top.sv
dv/tb_clkgen.sv
dv/tb_rv_core.sv

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  rv_pkg::reg_addr_t   i_rs1,
    input  rv_pkg::reg_addr_t   i_rs2,
    input  rv_pkg::ir_class_e   i_id_class,
    input  rv_pkg::ir_class_e   i_ex_class,
    input  rv_pkg::ir_class_e   i_mem_class,
    input  rv_pkg::reg_addr_t   i_ex_rd,
    input  rv_pkg::reg_addr_t   i_mem_rd,
    input  logic                i_ex_wr_en,
    input  logic                i_mem_wr_en,
    input  logic                i_jump,
    input  logic                i_acki_n,
    input  logic                i_ackd_n,
    output rv_pkg::fwd_sel_e    o_fwd1,
    output rv_pkg::fwd_sel_e    o_fwd2,
    output logic                o_stall,
    output logic                o_flush,
    output logic                o_interlock
);

    logic uses_rs1;
    logic uses_rs2;
    logic ex_load;

    // EX wins over MEM, x0 always from the register file
    function automatic rv_pkg::fwd_sel_e fwd_pick(input rv_pkg::reg_addr_t rs);
        rv_pkg::fwd_sel_e sel;
        sel = rv_pkg::REGFILE;
        if (rs != '0) begin
            if (i_ex_wr_en && i_ex_rd == rs) begin
                sel = rv_pkg::FROM_EX;
            end else if (i_mem_wr_en && i_mem_rd == rs) begin
                sel = rv_pkg::FROM_MEM;
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd1 = fwd_pick(i_rs1);
        o_fwd2 = fwd_pick(i_rs2);
    end

    // Only real source fields count for the stall
    assign uses_rs1 = !(i_id_class inside {rv_pkg::NONE, rv_pkg::LUI, rv_pkg::JAL});
    assign uses_rs2 = i_id_class inside {rv_pkg::ALU_R, rv_pkg::STORE, rv_pkg::BRANCH};
    assign ex_load  = (i_ex_class == rv_pkg::LOAD) && i_ex_wr_en && (i_ex_rd != '0);

    assign o_stall = ex_load && ((uses_rs1 && i_rs1 == i_ex_rd) ||
                                 (uses_rs2 && i_rs2 == i_ex_rd));
    assign o_flush = i_jump;

    assign o_interlock = i_acki_n ||
                         (i_ackd_n && (i_mem_class == rv_pkg::LOAD ||
                                       i_mem_class == rv_pkg::STORE));

endmodule

// ==== rtl/if_stage.sv ====
`timescale 1ns/100ps
`include "rv_params.svh"

module if_stage (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_stall,
    input  logic          i_interlock,
    input  logic          i_flush,
    input  rv_pkg::word_t i_jump_target,
    input  rv_pkg::word_t i_idt,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_id_pc,
    output rv_pkg::word_t o_id_pc4,
    output rv_pkg::word_t o_id_ir
);

    rv_pkg::word_t pc4;

    assign pc4 = o_pc + 32'd4;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc    <= `RV_RESET_VECTOR;
            o_id_ir <= `RV_NOP;
        end else if (!i_interlock) begin
            if (i_flush) begin
                o_pc    <= i_jump_target;
                o_id_ir <= `RV_NOP;
            end else if (!i_stall) begin
                o_pc    <= pc4;
                o_id_ir <= i_idt;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_interlock && !i_stall) begin
            o_id_pc  <= o_pc;
            o_id_pc4 <= pc4;
        end
    end

    // IF/ID never takes an undriven fetch word
    assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_interlock && !i_stall && !i_flush) |-> !$isunknown(i_idt));

endmodule

// ==== rtl/mem_wb_stage.sv ====
`timescale 1ns/100ps

module mem_wb_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_interlock,
    input  rv_pkg::word_t       i_mem_result,
    input  rv_pkg::word_t       i_mem_store_data,
    input  rv_pkg::word_t       i_mem_pc4,
    input  rv_pkg::reg_addr_t   i_mem_rd,
    input  logic                i_mem_wr_en,
    input  rv_pkg::ir_class_e   i_mem_class,
    input  rv_pkg::word_t       i_ddt,
    output rv_pkg::word_t       o_dad,
    output rv_pkg::word_t       o_ddt,
    output logic                o_mreq,
    output logic                o_write,
    output logic [1:0]          o_size,
    output rv_pkg::word_t       o_mem_fwd,
    output rv_pkg::reg_addr_t   o_wb_rd,
    output rv_pkg::word_t       o_wb_data,
    output logic                o_wb_en
);

    assign o_dad   = i_mem_result;
    assign o_ddt   = i_mem_store_data;
    assign o_mreq  = (i_mem_class == rv_pkg::LOAD) || (i_mem_class == rv_pkg::STORE);
    assign o_write = (i_mem_class == rv_pkg::STORE);
    // Word accesses only
    assign o_size  = 2'b10;

    always_comb begin
        case (i_mem_class)
            rv_pkg::LOAD: o_mem_fwd = i_ddt;
            rv_pkg::JAL:  o_mem_fwd = i_mem_pc4;
            default:      o_mem_fwd = i_mem_result;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
        end else if (!i_interlock) begin
            o_wb_en <= i_mem_wr_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_interlock) begin
            o_wb_rd   <= i_mem_rd;
            o_wb_data <= o_mem_fwd;
        end
    end

    // A waiting store keeps its request, address and data
    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_write && i_interlock) |=> (o_write && o_mreq && $stable(o_dad) && $stable(o_ddt)));

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps
`include "rv_params.svh"

module regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_wr_en,
    input  rv_pkg::reg_addr_t   i_wr_addr,
    input  rv_pkg::reg_addr_t   i_rd1_addr,
    input  rv_pkg::reg_addr_t   i_rd2_addr,
    input  rv_pkg::word_t       i_wr_data,
    output rv_pkg::word_t       o_rd1_data,
    output rv_pkg::word_t       o_rd2_data
);

    rv_pkg::word_t  regs [`RV_NUM_REGS];
    logic           wr_valid;

    // x0 never written
    assign wr_valid = i_wr_en && (i_wr_addr != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle write bypass
    assign o_rd1_data = (wr_valid && i_wr_addr == i_rd1_addr) ? i_wr_data : regs[i_rd1_addr];
    assign o_rd2_data = (wr_valid && i_wr_addr == i_rd2_addr) ? i_wr_data : regs[i_rd2_addr];

endmodule

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/100ps

module rv_core_top (
    input  logic          clk,
    input  logic          i_rst,
    output rv_pkg::word_t o_iad,
    input  rv_pkg::word_t i_idt,
    input  logic          i_acki_n,
    output rv_pkg::word_t o_dad,
    output rv_pkg::word_t o_ddt,
    input  rv_pkg::word_t i_ddt,
    output logic          o_mreq,
    output logic          o_write,
    output logic [1:0]    o_size,
    input  logic          i_ackd_n
);

    rv_pkg::word_t      id_pc, id_pc4, id_ir;
    rv_pkg::reg_addr_t  rs1, rs2;
    rv_pkg::ir_class_e  id_class, ex_class, mem_class;
    rv_pkg::word_t      rf_data1, rf_data2;
    rv_pkg::fwd_sel_e   fwd1, fwd2;
    rv_pkg::alu_op_e    ex_alu_op;
    rv_pkg::word_t      ex_op1, ex_op2, ex_imm, ex_pc, ex_pc4;
    rv_pkg::reg_addr_t  ex_rd, mem_rd, wb_rd;
    logic               ex_wr_en, mem_wr_en, wb_en;
    logic               jump;
    rv_pkg::word_t      jump_target, ex_result;
    rv_pkg::word_t      mem_result, mem_store_data, mem_pc4, mem_fwd;
    rv_pkg::word_t      wb_data;
    logic               stall, flush, interlock;

    if_stage if_stage_i (
        .i_clk(clk), .i_rst(i_rst),
        .i_stall(stall), .i_interlock(interlock), .i_flush(flush),
        .i_jump_target(jump_target), .i_idt(i_idt),
        .o_pc(o_iad), .o_id_pc(id_pc), .o_id_pc4(id_pc4), .o_id_ir(id_ir)
    );

    id_stage id_stage_i (
        .i_clk(clk), .i_rst(i_rst),
        .i_stall(stall), .i_flush(flush), .i_interlock(interlock),
        .i_pc(id_pc), .i_pc4(id_pc4), .i_ir(id_ir),
        .i_rf_data1(rf_data1), .i_rf_data2(rf_data2),
        .i_fwd_ex(ex_result), .i_fwd_mem(mem_fwd),
        .i_fwd1(fwd1), .i_fwd2(fwd2),
        .o_rs1(rs1), .o_rs2(rs2), .o_id_class(id_class),
        .o_ex_class(ex_class), .o_ex_alu_op(ex_alu_op),
        .o_ex_op1(ex_op1), .o_ex_op2(ex_op2), .o_ex_imm(ex_imm),
        .o_ex_pc(ex_pc), .o_ex_pc4(ex_pc4),
        .o_ex_rd(ex_rd), .o_ex_wr_en(ex_wr_en)
    );

    ex_stage ex_stage_i (
        .i_clk(clk), .i_rst(i_rst), .i_interlock(interlock),
        .i_ex_class(ex_class), .i_ex_alu_op(ex_alu_op),
        .i_ex_op1(ex_op1), .i_ex_op2(ex_op2), .i_ex_imm(ex_imm),
        .i_ex_pc(ex_pc), .i_ex_pc4(ex_pc4),
        .i_ex_rd(ex_rd), .i_ex_wr_en(ex_wr_en),
        .o_jump(jump), .o_jump_target(jump_target), .o_ex_result(ex_result),
        .o_mem_result(mem_result), .o_mem_store_data(mem_store_data),
        .o_mem_pc4(mem_pc4), .o_mem_rd(mem_rd),
        .o_mem_wr_en(mem_wr_en), .o_mem_class(mem_class)
    );

    mem_wb_stage mem_wb_stage_i (
        .i_clk(clk), .i_rst(i_rst), .i_interlock(interlock),
        .i_mem_result(mem_result), .i_mem_store_data(mem_store_data),
        .i_mem_pc4(mem_pc4), .i_mem_rd(mem_rd),
        .i_mem_wr_en(mem_wr_en), .i_mem_class(mem_class),
        .i_ddt(i_ddt),
        .o_dad(o_dad), .o_ddt(o_ddt), .o_mreq(o_mreq), .o_write(o_write), .o_size(o_size),
        .o_mem_fwd(mem_fwd),
        .o_wb_rd(wb_rd), .o_wb_data(wb_data), .o_wb_en(wb_en)
    );

    regfile regfile_i (
        .i_clk(clk), .i_rst(i_rst),
        .i_wr_en(wb_en), .i_wr_addr(wb_rd),
        .i_rd1_addr(rs1), .i_rd2_addr(rs2),
        .i_wr_data(wb_data),
        .o_rd1_data(rf_data1), .o_rd2_data(rf_data2)
    );

    hazard_unit hazard_unit_i (
        .i_rs1(rs1), .i_rs2(rs2),
        .i_id_class(id_class), .i_ex_class(ex_class), .i_mem_class(mem_class),
        .i_ex_rd(ex_rd), .i_mem_rd(mem_rd),
        .i_ex_wr_en(ex_wr_en), .i_mem_wr_en(mem_wr_en),
        .i_jump(jump), .i_acki_n(i_acki_n), .i_ackd_n(i_ackd_n),
        .o_fwd1(fwd1), .o_fwd2(fwd2),
        .o_stall(stall), .o_flush(flush), .o_interlock(interlock)
    );

endmodule
